//--- verilog/iso14443a_params.svh
// timing, buffer depth and CRC_A constants shared by the transmit path, include where needed
`ifndef ISO14443A_PARAMS_SVH
`define ISO14443A_PARAMS_SVH

// one bit time on the PICC to PCD link is 128 carrier cycles
// ISO/IEC 14443-2 type A, 106 kbit/s
`define TX_BIT_TICKS 128

// tick of the mid-bit transition of the Manchester code
// the serialiser is also asked for its next bit here
`define TX_HALF_TICKS 64

// byte buffer depth between the CRC producer and the serialiser
// the producer starts with this many credits, so a frame
// including its CRC bytes must fit in this many entries
`define TX_FIFO_DEPTH 16

// CRC_A from ISO/IEC 14443-3, processed LSB first
// the preset is loaded at every frame start, there is no final xor
`define TX_CRC_A_PRESET 16'h6363

// reflected form of x^16 + x^12 + x^5 + 1
`define TX_CRC_A_POLY 16'h8408

`endif

//--- verilog/iso14443a_pkg.sv
// types shared by the transmit path modules and interfaces, imported where used
package iso14443a_pkg;

    // one frame byte as it travels from the host to the serialiser
    typedef logic [7:0] tx_byte_t;

    // frame serialiser FSM
    // idle waits for a complete frame in the buffer
    // soc sends the start of communication bit
    // data walks through the eight bits of the head byte
    // parity sends the odd parity bit and pops the byte
    // wait_end lets the final bit time run out
    typedef enum logic [2:0] {
        SER_IDLE,
        SER_SOC,
        SER_DATA,
        SER_PARITY,
        SER_WAIT_END
    } ser_state_t;

    // CRC producer FSM
    // pass forwards host bytes, crc_lo and crc_hi emit the two CRC bytes
    typedef enum logic [1:0] {
        CRC_PASS,
        CRC_LO,
        CRC_HI
    } crc_state_t;

endpackage

//--- verilog/tx_interfaces.sv
// interfaces that link the producer, the byte buffer, the serialiser and the bit encoder
`timescale 1ns/1ps

// producer to buffer, credit based with no ready
// credit pulses once for every byte the buffer pops
interface byte_credit_if import iso14443a_pkg::*; ();
    logic     valid;
    tx_byte_t data;
    logic     last;
    logic     credit;

    modport send (output valid, data, last, input credit);
    modport recv (input valid, data, last, output credit);
endinterface

// buffer to serialiser, head entry is always visible
// pop takes the head away at the same edge
interface fifo_read_if import iso14443a_pkg::*; ();
    logic     pop;
    tx_byte_t data;
    logic     last;
    logic     frame_ready;

    modport reader (output pop, input data, last, frame_ready);
    modport store (input pop, output data, last, frame_ready);
endinterface

// serialiser to Manchester encoder, one bit per bit time
// active enables the encoder, req asks for the next bit at mid-bit
interface tx_interface;
    logic data;
    logic req;
    logic last_tick;
    logic active;

    modport in_bit (input data, active, output req, last_tick);
    modport out_bit (output data, active, input req, last_tick);
endinterface

//--- verilog/crc_a_appender.sv
// producer that takes host bytes, spends buffer credits and appends CRC_A to frames on request
`timescale 1ns/1ps
`include "iso14443a_params.svh"

module crc_a_appender import iso14443a_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  tx_byte_t      in_data,
    input  logic          in_last,
    input  logic          in_append_crc,
    output logic          in_ready,
    byte_credit_if.send   tx
);
    // the counter must hold the full depth, so one bit more than the pointer
    localparam int CREDIT_W = $clog2(`TX_FIFO_DEPTH + 1);

    crc_state_t          state;
    logic [CREDIT_W-1:0] credits;
    logic [15:0]         crc;
    logic [15:0]         crc_next;
    logic                host_accept;
    logic                crc_send;
    logic                spend;

    // one byte step of CRC_A, data enters LSB first
    function automatic logic [15:0] crc_a_step(input logic [15:0] crc_in,
                                               input tx_byte_t    byte_in);
        logic [15:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ byte_in[i]) begin
                c = (c >> 1) ^ `TX_CRC_A_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // host may only push while a buffer slot is paid for and no CRC is going out
    assign in_ready    = (state == CRC_PASS) && (credits != '0);
    assign host_accept = in_valid && in_ready;

    // a CRC byte goes out in the CRC states whenever a credit is held
    assign crc_send = (state != CRC_PASS) && (credits != '0);
    assign spend    = host_accept || crc_send;

    assign crc_next = crc_a_step(crc, in_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= CRC_PASS;
            credits  <= CREDIT_W'(`TX_FIFO_DEPTH);
            crc      <= `TX_CRC_A_PRESET;
            tx.valid <= 1'b0;
        end else begin
            // returned and spent credits can land on the same edge
            credits  <= credits + CREDIT_W'(tx.credit) - CREDIT_W'(spend);
            tx.valid <= spend;

            case (state)
                CRC_PASS: begin
                    if (host_accept) begin
                        if (in_last && !in_append_crc) begin
                            // frame ends here, next byte starts a fresh CRC
                            crc <= `TX_CRC_A_PRESET;
                        end else begin
                            crc <= crc_next;
                        end
                        if (in_last && in_append_crc) begin
                            state <= CRC_LO;
                        end
                    end
                end
                CRC_LO: begin
                    if (crc_send) begin
                        state <= CRC_HI;
                    end
                end
                CRC_HI: begin
                    if (crc_send) begin
                        state <= CRC_PASS;
                        crc   <= `TX_CRC_A_PRESET;
                    end
                end
                default: begin
                    state <= CRC_PASS;
                end
            endcase
        end
    end

    // byte and frame-end flag, only looked at when valid is high
    always_ff @(posedge clk) begin
        if (host_accept) begin
            tx.data <= in_data;
            // the last flag moves onto the high CRC byte when CRC is appended
            tx.last <= in_last && !in_append_crc;
        end else if (state == CRC_LO) begin
            // CRC_A goes out low byte first
            tx.data <= crc[7:0];
            tx.last <= 1'b0;
        end else if (state == CRC_HI) begin
            tx.data <= crc[15:8];
            tx.last <= 1'b1;
        end
    end

endmodule

//--- verilog/tx_byte_fifo.sv
// circular byte buffer with frame-end flags that counts whole frames and returns credits on pop
`timescale 1ns/1ps
`include "iso14443a_params.svh"

module tx_byte_fifo import iso14443a_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    byte_credit_if.recv  wr,
    fifo_read_if.store   rd
);
    localparam int PTR_W = $clog2(`TX_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`TX_FIFO_DEPTH + 1);

    tx_byte_t         data_mem [`TX_FIFO_DEPTH];
    logic             last_mem [`TX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] frame_cnt;
    logic             frame_in;
    logic             frame_out;

    // the producer never pushes without a credit, so there is no full check

    // storage, written on every push
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            data_mem[wr_ptr] <= wr.data;
            last_mem[wr_ptr] <= wr.last;
        end
    end

    // head entry is shown straight from the array
    assign rd.data = data_mem[rd_ptr];
    assign rd.last = last_mem[rd_ptr];

    // a frame enters with its last byte and leaves when that byte is popped
    assign frame_in  = wr.valid && wr.last;
    assign frame_out = rd.pop && rd.last;

    // serialiser only starts on a frame that is fully stored
    assign rd.frame_ready = (frame_cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
            wr.credit <= 1'b0;
        end else begin
            if (wr.valid) begin
                if (wr_ptr == PTR_W'(`TX_FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd.pop) begin
                if (rd_ptr == PTR_W'(`TX_FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            frame_cnt <= frame_cnt + CNT_W'(frame_in) - CNT_W'(frame_out);
            // every freed slot goes back to the producer one cycle later
            wr.credit <= rd.pop;
        end
    end

endmodule

//--- verilog/frame_serialiser.sv
// FSM that pops complete frames and feeds SOC, data bits LSB first and odd parity to the encoder
`timescale 1ns/1ps

module frame_serialiser import iso14443a_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    fifo_read_if.reader    rd,
    tx_interface.out_bit   bits
);
    ser_state_t state;
    logic [2:0] bit_idx;
    logic [2:0] next_idx;
    logic       par_acc;
    logic       load_pending;

    // the head byte stays in the buffer until its parity bit is requested,
    // so data bits are taken straight from rd.data
    assign next_idx = bit_idx + 3'd1;

    // popping at the parity request frees the slot as early as possible
    assign rd.pop = (state == SER_PARITY) && bits.req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= SER_IDLE;
            bits.active  <= 1'b0;
            bits.data    <= 1'b0;
            bit_idx      <= '0;
            par_acc      <= 1'b1;
            load_pending <= 1'b0;
        end else begin
            case (state)
                SER_IDLE: begin
                    // SOC is a logic 1, presented together with active
                    if (rd.frame_ready) begin
                        state       <= SER_SOC;
                        bits.active <= 1'b1;
                        bits.data   <= 1'b1;
                    end
                end
                SER_SOC: begin
                    if (bits.req) begin
                        state        <= SER_DATA;
                        load_pending <= 1'b1;
                    end
                end
                SER_DATA: begin
                    if (load_pending) begin
                        // first bit of a byte, loaded a cycle after the request
                        // because the head may have just been popped
                        load_pending <= 1'b0;
                        bit_idx      <= '0;
                        bits.data    <= rd.data[0];
                        // odd parity starts from 1 and folds in every data bit
                        par_acc      <= ~rd.data[0];
                    end else if (bits.req) begin
                        if (bit_idx == 3'd7) begin
                            state     <= SER_PARITY;
                            bits.data <= par_acc;
                        end else begin
                            bit_idx   <= next_idx;
                            bits.data <= rd.data[next_idx];
                            par_acc   <= par_acc ^ rd.data[next_idx];
                        end
                    end
                end
                SER_PARITY: begin
                    if (bits.req) begin
                        if (rd.last) begin
                            state <= SER_WAIT_END;
                        end else begin
                            state        <= SER_DATA;
                            load_pending <= 1'b1;
                        end
                    end
                end
                SER_WAIT_END: begin
                    // parity bit of the final byte runs to its last tick
                    if (bits.last_tick) begin
                        state       <= SER_IDLE;
                        bits.active <= 1'b0;
                    end
                end
                default: begin
                    state <= SER_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/bit_encoder.sv
// Manchester encoder that turns one requested bit per bit time into the transmit envelope
`timescale 1ns/1ps
`include "iso14443a_params.svh"

module bit_encoder (
    input  logic         clk,
    input  logic         rst_n,
    tx_interface.in_bit  in_iface,
    output logic         encoded_data,
    output logic         last_tick
);
    localparam int CNT_W = $clog2(`TX_BIT_TICKS);

    // position inside the current bit time
    logic [CNT_W-1:0] tick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick         <= '0;
            encoded_data <= 1'b0;
        end else begin
            if (in_iface.active) begin
                if (tick == CNT_W'(`TX_BIT_TICKS - 1)) begin
                    tick <= '0;
                end else begin
                    tick <= tick + 1'b1;
                end

                // a 1 is high then low, a 0 is low then high
                // so the first half simply follows the bit
                if (tick == '0) begin
                    encoded_data <= in_iface.data;
                end else if (tick == CNT_W'(`TX_HALF_TICKS)) begin
                    encoded_data <= ~encoded_data;
                end
            end else begin
                // line stays unmodulated between frames
                tick         <= '0;
                encoded_data <= 1'b0;
            end
        end
    end

    // the counter sits at zero while inactive, so neither strobe fires then
    assign last_tick = (tick == CNT_W'(`TX_BIT_TICKS - 1));
    assign in_iface.last_tick = last_tick;

    // the next bit is asked for at mid-bit, leaving half a bit time to present it
    assign in_iface.req = (tick == CNT_W'(`TX_HALF_TICKS));

endmodule

//--- verilog/tx_path_top.sv
// top level of the transmit path with host byte ports in and the Manchester envelope out
`timescale 1ns/1ps

module tx_path_top import iso14443a_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  tx_byte_t in_data,
    input  logic     in_last,
    input  logic     in_append_crc,
    output logic     in_ready,
    output logic     tx_data,
    output logic     tx_active
);
    byte_credit_if byte_bus ();
    fifo_read_if   fifo_rd ();
    tx_interface   tx_bits ();

    // host bytes with CRC_A appended on request
    crc_a_appender u_crc_a_appender (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_last       (in_last),
        .in_append_crc (in_append_crc),
        .in_ready      (in_ready),
        .tx            (byte_bus.send)
    );

    tx_byte_fifo u_tx_byte_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (byte_bus.recv),
        .rd    (fifo_rd.store)
    );

    frame_serialiser u_frame_serialiser (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (fifo_rd.reader),
        .bits  (tx_bits.out_bit)
    );

    // end of bit is also seen by the serialiser through the interface
    bit_encoder u_bit_encoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_iface     (tx_bits.in_bit),
        .encoded_data (tx_data),
        .last_tick    ()
    );

    // active is high for the whole frame, SOC through final parity
    assign tx_active = tx_bits.active;

endmodule

//--- dv/tb_clock_gen.sv
// testbench clock and reset source, 4 ns clock with reset held low for eight cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    // half period of 2 ns gives the 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset is released on a falling edge, away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- dv/tx_path_tb.sv
// testbench for the transmit path that drives host frames and decodes the Manchester line output
`timescale 1ns/1ps
`include "iso14443a_params.svh"

module tx_path_tb;
    localparam int BT = `TX_BIT_TICKS;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic [7:0] in_data;
    logic       in_last;
    logic       in_append_crc;
    logic       in_ready;
    logic       tx_data;
    logic       tx_active;

    // every frame in the table is a slice of fr_data
    logic [7:0] fr_data[$];
    int         fr_first[$];
    int         fr_n[$];
    bit         fr_crc[$];
    // expected line content is filled as frames are handed to the DUT
    logic [7:0] exp_data[$];
    int         exp_len[$];
    logic [7:0] rx[$];

    int   seed = 68;
    int   errors = 0;
    int   checks = 0;
    int   frames_sent = 0;
    int   frames_done = 0;
    int   host_acc = 0;
    int   parity_started = 0;
    int   stall_cycles = 0;
    int   cyc;
    int   pos;
    int   bitn;
    int   len;
    int   n;
    bit   in_frame = 0;
    bit   started = 0;
    bit   burst_mode = 0;
    logic first_half;
    logic bitval;
    logic [7:0] cur;
    logic [7:0] e;

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    tx_path_top UUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
        .in_last(in_last), .in_append_crc(in_append_crc), .in_ready(in_ready),
        .tx_data(tx_data), .tx_active(tx_active)
    );

    task automatic fail_value(input string name, input int got, input int expv);
        errors++;
        $display("Fail time=%0t signal=%s got=%0h expected=%0h", $time, name, got, expv);
    endtask

    // byte-wise CRC_A update as given in ISO/IEC 14443-3 annex B
    function automatic logic [15:0] crc_a_model(input int first, input int cnt);
        logic [15:0] crc;
        logic [7:0]  ch;
        crc = `TX_CRC_A_PRESET;
        for (int i = 0; i < cnt; i++) begin
            ch  = fr_data[first + i] ^ crc[7:0];
            ch  = ch ^ (ch << 4);
            crc = (crc >> 8) ^ (16'(ch) << 8) ^ (16'(ch) << 3) ^ (16'(ch) >> 4);
        end
        return crc;
    endfunction

    task automatic add_frame(input int cnt, input bit crc, input bit rnd, input logic [7:0] val);
        fr_first.push_back(fr_data.size());
        fr_n.push_back(cnt);
        fr_crc.push_back(crc);
        for (int i = 0; i < cnt; i++) begin
            fr_data.push_back(rnd ? 8'($random(seed)) : val);
        end
    endtask

    // hands one frame to the host port and holds each byte until in_ready accepts it
    task automatic send_frame(input int idx);
        logic [15:0] crc;
        for (int i = 0; i < fr_n[idx]; i++) begin
            exp_data.push_back(fr_data[fr_first[idx] + i]);
        end
        crc = crc_a_model(fr_first[idx], fr_n[idx]);
        if (fr_crc[idx]) begin
            exp_data.push_back(crc[7:0]);
            exp_data.push_back(crc[15:8]);
        end
        exp_len.push_back(fr_n[idx] + (fr_crc[idx] ? 2 : 0));
        frames_sent++;
        started = 1;
        for (int i = 0; i < fr_n[idx]; i++) begin
            @(negedge clk);
            in_valid      = 1'b1;
            in_data       = fr_data[fr_first[idx] + i];
            in_last       = (i == fr_n[idx] - 1);
            in_append_crc = fr_crc[idx];
            while (!in_ready) @(negedge clk);
        end
    endtask

    task automatic wait_line_idle();
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;
        while (frames_done < frames_sent) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // host side counters are sampled before the DUT registers update
    always @(posedge clk) begin
        if (in_valid && in_ready) host_acc++;
        if (burst_mode && in_valid && !in_ready) stall_cycles++;
    end

    // cycle 0 of the line decoder is the first edge that sees tx_active high
    always @(posedge clk) begin
        if (tx_active) begin
            if (!in_frame) begin
                in_frame = 1;
                cyc      = 0;
                rx.delete();
            end else begin
                cyc++;
            end
            pos  = cyc % BT;
            bitn = cyc / BT;
            if (pos == 32) begin
                first_half = tx_data;
                // the parity bit has begun and its byte has not been popped yet
                if (bitn > 0 && (bitn - 1) % 9 == 8) parity_started++;
            end
            if (pos == 96) begin
                bitval = first_half;
                checks++;
                assert (tx_data == ~first_half)
                    else fail_value("tx_data", tx_data, !first_half);
                if (bitn == 0) begin
                    checks++;
                    assert (bitval == 1'b1) else fail_value("soc_bit", bitval, 1);
                end else if ((bitn - 1) % 9 < 8) begin
                    cur[(bitn - 1) % 9] = bitval;
                end else begin
                    checks++;
                    assert (bitval == ~^cur) else fail_value("parity_bit", bitval, ~^cur);
                    rx.push_back(cur);
                end
            end
        end else if (in_frame) begin
            in_frame = 0;
            len      = cyc + 1;
            if (exp_len.size() == 0) begin
                errors++;
                $display("error at %0t: a frame was sent while none was expected", $time);
            end else begin
                n = exp_len.pop_front();
                checks++;
                assert (len == (1 + 9 * n) * BT)
                    else fail_value("tx_active_cycles", len, (1 + 9 * n) * BT);
                assert (rx.size() == n) else fail_value("frame_bytes", rx.size(), n);
                for (int i = 0; i < n; i++) begin
                    e = exp_data.pop_front();
                    checks++;
                    if (i < rx.size()) begin
                        assert (rx[i] == e) else fail_value("frame_byte", rx[i], e);
                    end
                end
            end
            frames_done++;
        end
    end

    // nothing moves on the line and the host port is open until the first byte
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!tx_active && in_ready))
        else begin
            errors++;
            $display("error at %0t: line active or host blocked before any input", $time);
        end

    // the host is held off while the two CRC bytes go out
    a_crc_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && in_ready && in_last && in_append_crc) |=> !in_ready)
        else begin
            errors++;
            $display("error at %0t: in_ready stayed high during CRC emission", $time);
        end

    // no more host bytes outstanding than the buffer can hold
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (host_acc - parity_started) <= `TX_FIFO_DEPTH)
        else begin
            errors++;
            $display("error at %0t: host got ahead of the buffer depth", $time);
        end

    initial begin
        int budget;
        in_valid      = 1'b0;
        in_data       = 8'h00;
        in_last       = 1'b0;
        in_append_crc = 1'b0;

        // frames 0 to 4 are the single and CRC tests, 5 to 8 the burst and the rest random
        add_frame(1, 0, 0, 8'hA5);
        add_frame(2, 1, 0, 8'h00);
        for (int i = 0; i < 3; i++) add_frame(1 + ($unsigned($random(seed)) % 6), 1, 1, 0);
        add_frame(14, 1, 1, 0);
        add_frame(14, 1, 1, 0);
        add_frame(12, 0, 1, 0);
        add_frame(10, 1, 1, 0);
        for (int i = 0; i < 12; i++) begin
            add_frame(1 + ($unsigned($random(seed)) % (`TX_FIFO_DEPTH - 2)),
                      $random(seed) & 1, 1, 0);
        end

        // summed frame bit times plus slack for gaps, idle checks and reset
        budget = 2000;
        for (int i = 0; i < fr_n.size(); i++) begin
            budget += (1 + 9 * (fr_n[i] + (fr_crc[i] ? 2 : 0))) * BT + 64;
        end
        fork
            begin
                #(budget * 4);
                $display("error: watchdog expired before all frames were sent");
                $display("TEST RESULT: FAIL");
                $finish;
            end
        join_none

        @(posedge rst_n);
        repeat (200) @(posedge clk);

        send_frame(0);
        wait_line_idle();
        for (int i = 1; i < 5; i++) begin
            send_frame(i);
            wait_line_idle();
        end

        // continuous push of frames larger than the buffer in total
        burst_mode = 1;
        for (int i = 5; i < 9; i++) send_frame(i);
        wait_line_idle();
        burst_mode = 0;
        checks++;
        assert (stall_cycles > 8) else begin
            errors++;
            $display("error: host was never held off by a full buffer in the burst");
        end

        for (int i = 9; i < fr_n.size(); i++) send_frame(i);
        wait_line_idle();

        checks++;
        assert (frames_done == fr_n.size()) else fail_value("frames_done", frames_done,
                                                           fr_n.size());
        $display("frames=%0d checks=%0d errors=%0d", frames_done, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
verilog/iso14443a_pkg.sv
verilog/tx_interfaces.sv
verilog/crc_a_appender.sv
verilog/tx_byte_fifo.sv
verilog/frame_serialiser.sv
verilog/bit_encoder.sv
verilog/tx_path_top.sv
dv/tb_clock_gen.sv
dv/tx_path_tb.sv

//--- Makefile
# Verilator build and run of the ISO 14443A transmit path testbench

VERILATOR ?= verilator
TOP       ?= tx_path_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
